// File: prach_front.f
+incdir+hw
hw/prach_sample_pkg.sv
hw/prach_ctrl_pkg.sv
hw/prach_capture_gate.sv
hw/prach_symbol_fifo.sv
hw/prach_read_sequencer.sv
hw/prach_bw_gain.sv
hw/prach_front.sv
tests/prach_front_checker.sv
tests/prach_front_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the prach_front testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f prach_front.f \
    --top-module prach_front_tb -o prach_front_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/prach_front_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
exit 0

// File: tests/prach_front_tb.sv
`include "prach_cfg.svh"

module prach_front_tb;

    // samples kept over all periods of all five tests
    localparam int TOTAL_SAMPLES = `PRACH_N_ANT * (`PRACH_LEN_F0 + `PRACH_LEN_F1
        + `PRACH_LEN_F2 + `PRACH_LEN_F3 + 4 * `PRACH_LEN_F2 + 2 * `PRACH_LEN_F3
        + 2 * `PRACH_LEN_F1);
    // input gaps, cp beats and stalls fit in four cycles per sample
    localparam int TIMEOUT_CYCLES = 4 * TOTAL_SAMPLES + 2000;
    // slowest drain of four full buffers after the last input beat
    localparam int DRAIN_CYCLES = 4 * `PRACH_N_ANT * `PRACH_FIFO_DEPTH;

    logic                          clk_dfe = 1'b0;
    logic                          reset_dfe;
    logic                          in_valid;
    prach_sample_pkg::iq_t         in_data;
    prach_sample_pkg::ant_id_t     in_ant;
    logic                          sub_frame_mrkr;
    logic [`PRACH_CP_W-1:0]        prach_cp;
    prach_ctrl_pkg::format_t       format;
    prach_ctrl_pkg::ch_bw_t        ch_bw;
    logic                          out_ready;
    logic                          out_valid;
    prach_sample_pkg::iq_t         out_data;
    prach_sample_pkg::ant_id_t     out_ant;
    prach_sample_pkg::sample_idx_t out_idx;
    logic                          out_last;

    // right shift for 20, 10, 5 and 15 MHz
    int shift_for_bw [4] = '{0, 1, 2, 1};
    int len_for_fmt  [4] = '{`PRACH_LEN_F0, `PRACH_LEN_F1, `PRACH_LEN_F2, `PRACH_LEN_F3};

    // one period of stimulus built in full before driving
    logic                      beat_valid [$];
    prach_sample_pkg::ant_id_t beat_ant   [$];
    prach_sample_pkg::iq_t     beat_data  [$];
    // samples the model keeps per antenna
    prach_sample_pkg::iq_t     captured   [`PRACH_N_ANT][`PRACH_FIFO_DEPTH];

    logic        ready_random = 1'b0;
    int          cycle_cnt = 0;
    int unsigned seed_init;

    always #2 clk_dfe = ~clk_dfe;

    prach_front i_dut (
        .clk_dfe        (clk_dfe),
        .reset_dfe      (reset_dfe),
        .in_valid       (in_valid),
        .in_data        (in_data),
        .in_ant         (in_ant),
        .sub_frame_mrkr (sub_frame_mrkr),
        .prach_cp       (prach_cp),
        .format         (format),
        .ch_bw          (ch_bw),
        .out_ready      (out_ready),
        .out_valid      (out_valid),
        .out_data       (out_data),
        .out_ant        (out_ant),
        .out_idx        (out_idx),
        .out_last       (out_last)
    );

    prach_front_checker i_chk (
        .clk_dfe   (clk_dfe),
        .reset_dfe (reset_dfe),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_ant   (out_ant),
        .out_idx   (out_idx),
        .out_last  (out_last)
    );

    // hard stop for a hung run
    always @(posedge clk_dfe) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with %0d expected beats still pending",
                     cycle_cnt, i_chk.pending());
            $display("Test FAILED");
            $finish;
        end
    end

    // I and Q each shifted right with sign
    function automatic prach_sample_pkg::iq_t scaled(input prach_sample_pkg::iq_t x,
                                                     input int bw);
        logic signed [`PRACH_IQ_W-1:0] i_part;
        logic signed [`PRACH_IQ_W-1:0] q_part;
        i_part = x[`PRACH_IQ_W-1:0];
        q_part = x[2*`PRACH_IQ_W-1:`PRACH_IQ_W];
        return {q_part >>> shift_for_bw[bw], i_part >>> shift_for_bw[bw]};
    endfunction

    // all inputs change on the falling edge
    task automatic next_cycle();
        @(negedge clk_dfe);
        out_ready = ready_random ? ($urandom % 2 == 1) : 1'b1;
    endtask

    // random beats plus the capture model
    // extra counts beats after every antenna has its block
    task automatic build_period(input int fmt, input int cp, input int bw, input int extra);
        int skip_n [`PRACH_N_ANT];
        int wr_n   [`PRACH_N_ANT];
        int done_n;
        int ant;
        int len;
        logic v;
        prach_sample_pkg::iq_t d;
        len    = len_for_fmt[fmt];
        done_n = 0;
        ant    = `PRACH_N_ANT - 1;
        beat_valid.delete();
        beat_ant.delete();
        beat_data.delete();
        for (int a = 0; a < `PRACH_N_ANT; a++) begin
            skip_n[a] = 0;
            wr_n[a]   = 0;
        end
        while (done_n < `PRACH_N_ANT || extra > 0) begin
            v = ($urandom % 4) != 0;
            // mostly round robin
            // now and then any antenna
            if (($urandom % 8) == 0) begin
                ant = int'($urandom % `PRACH_N_ANT);
            end else begin
                ant = (ant + 1) % `PRACH_N_ANT;
            end
            d = $urandom;
            beat_valid.push_back(v);
            beat_ant.push_back(prach_sample_pkg::ant_id_t'(ant));
            beat_data.push_back(d);
            if (v) begin
                if (done_n == `PRACH_N_ANT) begin
                    extra--;
                end
                if (skip_n[ant] < cp) begin
                    skip_n[ant]++;
                end else if (wr_n[ant] < len) begin
                    captured[ant][wr_n[ant]] = d;
                    wr_n[ant]++;
                    if (wr_n[ant] == len) begin
                        done_n++;
                    end
                end
            end
        end
        // blocks come out antenna by antenna
        for (int a = 0; a < `PRACH_N_ANT; a++) begin
            for (int k = 0; k < len; k++) begin
                i_chk.expect_beat(scaled(captured[a][k], bw), prach_sample_pkg::ant_id_t'(a),
                                  prach_sample_pkg::sample_idx_t'(k), k == len - 1);
            end
        end
    endtask

    // marker, beats, then wait for the drain
    task automatic run_period(input int fmt, input int cp, input int bw, input int extra);
        int waited;
        build_period(fmt, cp, bw, extra);
        waited = 0;
        next_cycle();
        in_valid = 1'b0;
        format   = prach_ctrl_pkg::format_t'(fmt);
        prach_cp = cp[`PRACH_CP_W-1:0];
        ch_bw    = prach_ctrl_pkg::ch_bw_t'(bw);
        next_cycle();
        sub_frame_mrkr = 1'b1;
        foreach (beat_valid[i]) begin
            next_cycle();
            sub_frame_mrkr = 1'b0;
            in_valid = beat_valid[i];
            in_ant   = beat_ant[i];
            in_data  = beat_data[i];
        end
        next_cycle();
        in_valid = 1'b0;
        // beats still missing after the limit stay queued for the test report
        while (i_chk.pending() != 0 && waited < DRAIN_CYCLES) begin
            next_cycle();
            waited++;
        end
        // quiet gap to catch stray beats
        repeat (8) next_cycle();
    endtask

    initial begin
        seed_init      = $urandom(35);
        reset_dfe      = 1'b1;
        in_valid       = 1'b0;
        in_data        = '0;
        in_ant         = '0;
        sub_frame_mrkr = 1'b0;
        prach_cp       = '0;
        format         = '0;
        ch_bw          = '0;
        out_ready      = 1'b1;
        repeat (5) @(posedge clk_dfe);
        next_cycle();
        reset_dfe = 1'b0;

        // first kept sample is beat 5 after the marker
        i_chk.start_test(1, "cp skip");
        run_period(0, 5, 0, 0);
        i_chk.end_test();

        i_chk.start_test(2, "block length and order");
        for (int f = 1; f < 4; f++) begin
            run_period(f, int'($urandom % 8), 0, 0);
        end
        i_chk.end_test();

        i_chk.start_test(3, "bandwidth gain");
        for (int b = 0; b < 4; b++) begin
            run_period(2, int'($urandom % 8), b, 0);
        end
        i_chk.end_test();

        // random out_ready stalls the gain stage
        ready_random = 1'b1;
        i_chk.start_test(4, "back-pressure");
        repeat (2) run_period(3, int'($urandom % 8), 3, 0);
        i_chk.end_test();
        ready_random = 1'b0;

        // beats past a full block until the next marker
        i_chk.start_test(5, "gating between markers");
        repeat (2) run_period(1, int'($urandom % 8), 1, 40);
        i_chk.end_test();

        i_chk.report_totals();
        if (i_chk.error_total() == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: tests/prach_front_checker.sv
`include "prach_cfg.svh"

module prach_front_checker (
    input  logic                          clk_dfe,
    input  logic                          reset_dfe,
    input  logic                          out_valid,
    input  logic                          out_ready,
    input  prach_sample_pkg::iq_t         out_data,
    input  prach_sample_pkg::ant_id_t     out_ant,
    input  prach_sample_pkg::sample_idx_t out_idx,
    input  logic                          out_last
);

    localparam int DATA_W = 2 * `PRACH_IQ_W;
    localparam int ANT_W  = $bits(prach_sample_pkg::ant_id_t);
    localparam int IDX_W  = $bits(prach_sample_pkg::sample_idx_t);
    localparam int BEAT_W = DATA_W + ANT_W + IDX_W + 1;

    // {last, idx, ant, data} in output order
    logic [BEAT_W-1:0] exp_q [$];
    logic [BEAT_W-1:0] seen;
    logic [BEAT_W-1:0] held;
    logic              stalled = 1'b0;

    int    test_num = 0;
    string test_name = "";
    int    test_beats = 0;
    int    test_errors = 0;
    int    total_tests = 0;
    int    failed_tests = 0;
    int    total_beats = 0;
    int    total_errors = 0;

    assign seen = {out_last, out_idx, out_ant, out_data};

    task automatic expect_beat(input prach_sample_pkg::iq_t data,
                               input prach_sample_pkg::ant_id_t ant,
                               input prach_sample_pkg::sample_idx_t idx,
                               input logic last);
        exp_q.push_back({last, idx, ant, data});
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    function automatic int error_total();
        return total_errors;
    endfunction

    task automatic start_test(input int num, input string name);
        test_num    = num;
        test_name   = name;
        test_beats  = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        // expected beats that never came out
        if (exp_q.size() != 0) begin
            $display("test %0d: %0d expected beats were never seen at the output",
                     test_num, exp_q.size());
            test_errors++;
            exp_q.delete();
        end
        total_tests++;
        total_beats  += test_beats;
        total_errors += test_errors;
        if (test_errors != 0) begin
            failed_tests++;
        end
        $display("test %0d %s: %0d beats checked, %0d errors, %s", test_num, test_name,
                 test_beats, test_errors, (test_errors == 0) ? "pass" : "fail");
    endtask

    task automatic report_totals();
        $display("totals: %0d tests, %0d failed, %0d beats checked, %0d errors",
                 total_tests, failed_tests, total_beats, total_errors);
    endtask

    task automatic report_mismatch(input string sig, input string when,
                                   input logic [31:0] got, input logic [31:0] exp);
        $display("mismatch %s %s: got 0x%0h expected 0x%0h (test %0d, beat %0d)",
                 sig, when, got, exp, test_num, test_beats);
        test_errors++;
    endtask

    // field by field, one line per wrong field
    task automatic compare_beat(input logic [BEAT_W-1:0] got, input logic [BEAT_W-1:0] exp,
                                input string when);
        if (got[DATA_W-1:0] !== exp[DATA_W-1:0]) begin
            report_mismatch("out_data", when, 32'(got[DATA_W-1:0]), 32'(exp[DATA_W-1:0]));
        end
        if (got[DATA_W+ANT_W-1:DATA_W] !== exp[DATA_W+ANT_W-1:DATA_W]) begin
            report_mismatch("out_ant", when, 32'(got[DATA_W+ANT_W-1:DATA_W]),
                            32'(exp[DATA_W+ANT_W-1:DATA_W]));
        end
        if (got[BEAT_W-2:DATA_W+ANT_W] !== exp[BEAT_W-2:DATA_W+ANT_W]) begin
            report_mismatch("out_idx", when, 32'(got[BEAT_W-2:DATA_W+ANT_W]),
                            32'(exp[BEAT_W-2:DATA_W+ANT_W]));
        end
        if (got[BEAT_W-1] !== exp[BEAT_W-1]) begin
            report_mismatch("out_last", when, 32'(got[BEAT_W-1]), 32'(exp[BEAT_W-1]));
        end
    endtask

    always @(posedge clk_dfe) begin
        if (reset_dfe) begin
            stalled = 1'b0;
        end else begin
            // beat stalled last cycle must still be there, unchanged
            if (stalled && !out_valid) begin
                $display("test %0d: out_valid dropped while out_ready was low", test_num);
                test_errors++;
            end else if (stalled) begin
                compare_beat(seen, held, "while stalled");
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("test %0d: unexpected output beat for antenna %0d index %0d",
                             test_num, out_ant, out_idx);
                    test_errors++;
                end else begin
                    compare_beat(seen, exp_q.pop_front(), "on transfer");
                    test_beats++;
                end
            end
            stalled = out_valid && !out_ready;
            held    = seen;
        end
    end

endmodule

// File: hw/prach_front.sv
`include "prach_cfg.svh"

module prach_front (
    input  logic                          clk_dfe,
    input  logic                          reset_dfe,
    input  logic                          in_valid,
    input  prach_sample_pkg::iq_t         in_data,
    input  prach_sample_pkg::ant_id_t     in_ant,
    input  logic                          sub_frame_mrkr,
    input  logic [`PRACH_CP_W-1:0]        prach_cp,
    input  prach_ctrl_pkg::format_t       format,
    input  prach_ctrl_pkg::ch_bw_t        ch_bw,
    input  logic                          out_ready,
    output logic                          out_valid,
    output prach_sample_pkg::iq_t         out_data,
    output prach_sample_pkg::ant_id_t     out_ant,
    output prach_sample_pkg::sample_idx_t out_idx,
    output logic                          out_last
);

    // gate to buffers
    logic [`PRACH_N_ANT-1:0]       wr_en;
    prach_sample_pkg::iq_t         wr_data;

    // buffers to sequencer
    logic [`PRACH_N_ANT-1:0]       rd_en;
    prach_sample_pkg::iq_t         fifo_data  [`PRACH_N_ANT];
    prach_ctrl_pkg::blk_len_t      fifo_count [`PRACH_N_ANT];

    // sequencer to gain
    logic                          seq_valid;
    logic                          seq_ready;
    prach_sample_pkg::iq_t         seq_data;
    prach_sample_pkg::ant_id_t     seq_ant;
    prach_sample_pkg::sample_idx_t seq_idx;
    logic                          seq_last;

    prach_capture_gate capture_gate_inst (
        .clk_dfe        (clk_dfe),
        .reset_dfe      (reset_dfe),
        .in_valid       (in_valid),
        .in_data        (in_data),
        .in_ant         (in_ant),
        .sub_frame_mrkr (sub_frame_mrkr),
        .prach_cp       (prach_cp),
        .format         (format),
        .wr_en          (wr_en),
        .wr_data        (wr_data)
    );

    // one symbol buffer per antenna
    // empty flag unused here, the sequencer works from the count
    for (genvar a = 0; a < `PRACH_N_ANT; a++) begin : g_ant_fifo
        prach_symbol_fifo symbol_fifo_inst (
            .clk_dfe   (clk_dfe),
            .reset_dfe (reset_dfe),
            .wr_en     (wr_en[a]),
            .wr_data   (wr_data),
            .rd_en     (rd_en[a]),
            .rd_data   (fifo_data[a]),
            .count     (fifo_count[a]),
            .empty     ()
        );
    end

    prach_read_sequencer read_sequencer_inst (
        .clk_dfe    (clk_dfe),
        .reset_dfe  (reset_dfe),
        .format     (format),
        .fifo_data  (fifo_data),
        .fifo_count (fifo_count),
        .seq_ready  (seq_ready),
        .rd_en      (rd_en),
        .seq_valid  (seq_valid),
        .seq_data   (seq_data),
        .seq_ant    (seq_ant),
        .seq_idx    (seq_idx),
        .seq_last   (seq_last)
    );

    prach_bw_gain bw_gain_inst (
        .clk_dfe   (clk_dfe),
        .reset_dfe (reset_dfe),
        .ch_bw     (ch_bw),
        .seq_valid (seq_valid),
        .seq_data  (seq_data),
        .seq_ant   (seq_ant),
        .seq_idx   (seq_idx),
        .seq_last  (seq_last),
        .out_ready (out_ready),
        .seq_ready (seq_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ant   (out_ant),
        .out_idx   (out_idx),
        .out_last  (out_last)
    );

endmodule

// File: hw/prach_bw_gain.sv
`include "prach_cfg.svh"

module prach_bw_gain (
    input  logic                          clk_dfe,
    input  logic                          reset_dfe,
    input  prach_ctrl_pkg::ch_bw_t        ch_bw,
    input  logic                          seq_valid,
    input  prach_sample_pkg::iq_t         seq_data,
    input  prach_sample_pkg::ant_id_t     seq_ant,
    input  prach_sample_pkg::sample_idx_t seq_idx,
    input  logic                          seq_last,
    input  logic                          out_ready,
    output logic                          seq_ready,
    output logic                          out_valid,
    output prach_sample_pkg::iq_t         out_data,
    output prach_sample_pkg::ant_id_t     out_ant,
    output prach_sample_pkg::sample_idx_t out_idx,
    output logic                          out_last
);

    logic [1:0]                     shift;
    logic signed [`PRACH_IQ_W-1:0]  in_i;
    logic signed [`PRACH_IQ_W-1:0]  in_q;
    logic signed [`PRACH_IQ_W-1:0]  gain_i;
    logic signed [`PRACH_IQ_W-1:0]  gain_q;
    logic                           load;

    assign shift = prach_ctrl_pkg::gain_shift(ch_bw);

    // split Q above I
    assign in_i = seq_data[`PRACH_IQ_W-1:0];
    assign in_q = seq_data[2*`PRACH_IQ_W-1:`PRACH_IQ_W];

    // sign kept by arithmetic shift
    assign gain_i = in_i >>> shift;
    assign gain_q = in_q >>> shift;

    // room when empty or emptying this cycle
    assign seq_ready = !out_valid || out_ready;
    assign load      = seq_valid && seq_ready;

    always_ff @(posedge clk_dfe) begin
        if (reset_dfe) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // payload and tags change only on a load, so they hold while stalled
    always_ff @(posedge clk_dfe) begin
        if (load) begin
            out_data <= {gain_q, gain_i};
            out_ant  <= seq_ant;
            out_idx  <= seq_idx;
            out_last <= seq_last;
        end
    end

endmodule

// File: hw/prach_read_sequencer.sv
`include "prach_cfg.svh"

module prach_read_sequencer (
    input  logic                         clk_dfe,
    input  logic                         reset_dfe,
    input  prach_ctrl_pkg::format_t      format,
    input  prach_sample_pkg::iq_t        fifo_data  [`PRACH_N_ANT],
    input  prach_ctrl_pkg::blk_len_t     fifo_count [`PRACH_N_ANT],
    input  logic                         seq_ready,
    output logic [`PRACH_N_ANT-1:0]      rd_en,
    output logic                         seq_valid,
    output prach_sample_pkg::iq_t        seq_data,
    output prach_sample_pkg::ant_id_t    seq_ant,
    output prach_sample_pkg::sample_idx_t seq_idx,
    output logic                         seq_last
);

    prach_ctrl_pkg::seq_state_t    state;
    prach_sample_pkg::ant_id_t     cur_ant;
    prach_sample_pkg::sample_idx_t idx;

    prach_ctrl_pkg::blk_len_t      blk_len;
    prach_ctrl_pkg::blk_len_t      cur_count;
    logic                          accept;
    logic                          pre_last;
    logic                          last_ant;

    assign blk_len   = prach_ctrl_pkg::block_len(format);
    assign cur_count = fifo_count[cur_ant];

    // head word valid only while draining and buffer not empty
    assign seq_valid = (state != prach_ctrl_pkg::seq_idle) && (cur_count != '0);
    assign accept    = seq_valid && seq_ready;

    // index of the sample before the last one
    assign pre_last = {1'b0, idx} == blk_len - 2'd2;
    assign last_ant = cur_ant == prach_sample_pkg::ant_id_t'(`PRACH_N_ANT - 1);

    // mux of the selected antenna's head word and tags
    assign seq_data = fifo_data[cur_ant];
    assign seq_ant  = cur_ant;
    assign seq_idx  = idx;

    // wait_last holds exactly the final sample of the block
    assign seq_last = state == prach_ctrl_pkg::seq_wait_last;

    // pop the head word as the gain stage takes it
    always_comb begin
        rd_en          = '0;
        rd_en[cur_ant] = accept;
    end

    // one loop over the antennas
    // drain takes samples 0 to len-2, wait_last takes the final one
    always_ff @(posedge clk_dfe) begin
        if (reset_dfe) begin
            state   <= prach_ctrl_pkg::seq_idle;
            cur_ant <= '0;
            idx     <= '0;
        end else begin
            case (state)
                prach_ctrl_pkg::seq_idle: begin
                    // antenna 0 holds a full block
                    if (fifo_count[0] >= blk_len) begin
                        state   <= prach_ctrl_pkg::seq_drain;
                        cur_ant <= '0;
                        idx     <= '0;
                    end
                end
                prach_ctrl_pkg::seq_drain: begin
                    if (accept) begin
                        idx <= idx + 1'b1;
                        if (pre_last) begin
                            state <= prach_ctrl_pkg::seq_wait_last;
                        end
                    end
                end
                prach_ctrl_pkg::seq_wait_last: begin
                    // last sample taken, next antenna or done
                    if (accept) begin
                        idx <= '0;
                        if (last_ant) begin
                            state   <= prach_ctrl_pkg::seq_idle;
                            cur_ant <= '0;
                        end else begin
                            state   <= prach_ctrl_pkg::seq_drain;
                            cur_ant <= cur_ant + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= prach_ctrl_pkg::seq_idle;
                end
            endcase
        end
    end

endmodule

// File: hw/prach_symbol_fifo.sv
`include "prach_cfg.svh"

module prach_symbol_fifo (
    input  logic                      clk_dfe,
    input  logic                      reset_dfe,
    input  logic                      wr_en,
    input  prach_sample_pkg::iq_t     wr_data,
    input  logic                      rd_en,
    output prach_sample_pkg::iq_t     rd_data,
    output prach_ctrl_pkg::blk_len_t  count,
    output logic                      empty
);

    localparam int PTR_W = $clog2(`PRACH_FIFO_DEPTH);

    // sample storage
    prach_sample_pkg::iq_t mem [`PRACH_FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_rd;

    assign empty = count == '0;

    // a pop on an empty buffer is ignored
    assign do_rd = rd_en && !empty;

    // show-ahead head word
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk_dfe) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // pointers wrap at the power of two depth
    always_ff @(posedge clk_dfe) begin
        if (reset_dfe) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // occupancy
            case ({wr_en, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: hw/prach_capture_gate.sv
`include "prach_cfg.svh"

module prach_capture_gate (
    input  logic                           clk_dfe,
    input  logic                           reset_dfe,
    input  logic                           in_valid,
    input  prach_sample_pkg::iq_t          in_data,
    input  prach_sample_pkg::ant_id_t      in_ant,
    input  logic                           sub_frame_mrkr,
    input  logic [`PRACH_CP_W-1:0]         prach_cp,
    input  prach_ctrl_pkg::format_t        format,
    output logic [`PRACH_N_ANT-1:0]        wr_en,
    output prach_sample_pkg::iq_t          wr_data
);

    // per antenna capture state
    logic [`PRACH_N_ANT-1:0]   armed;
    logic [`PRACH_CP_W-1:0]    skip_cnt [`PRACH_N_ANT];
    prach_ctrl_pkg::blk_len_t  wr_cnt   [`PRACH_N_ANT];

    // selected by the antenna of the current beat
    prach_ctrl_pkg::blk_len_t  blk_len;
    logic                      beat_armed;
    logic                      in_cp;
    logic                      last_wr;

    assign blk_len = prach_ctrl_pkg::block_len(format);

    // only beats of an armed antenna count
    assign beat_armed = in_valid && armed[in_ant];

    // still inside this antenna's cyclic prefix
    assign in_cp = skip_cnt[in_ant] < prach_cp;

    // final sample of the block for this antenna
    assign last_wr = wr_cnt[in_ant] == blk_len - 1'b1;

    always_ff @(posedge clk_dfe) begin
        if (reset_dfe) begin
            armed <= '0;
            wr_en <= '0;
            for (int a = 0; a < `PRACH_N_ANT; a++) begin
                skip_cnt[a] <= '0;
                wr_cnt[a]   <= '0;
            end
        end else begin
            wr_en <= '0;
            if (sub_frame_mrkr) begin
                // new subframe
                // rearm every antenna, a beat in the marker cycle is not taken
                armed <= '1;
                for (int a = 0; a < `PRACH_N_ANT; a++) begin
                    skip_cnt[a] <= '0;
                    wr_cnt[a]   <= '0;
                end
            end else if (beat_armed) begin
                if (in_cp) begin
                    // drop and count cp samples
                    skip_cnt[in_ant] <= skip_cnt[in_ant] + 1'b1;
                end else begin
                    wr_en[in_ant]  <= 1'b1;
                    wr_cnt[in_ant] <= wr_cnt[in_ant] + 1'b1;
                    // block complete
                    // ignore this antenna until the next marker
                    if (last_wr) begin
                        armed[in_ant] <= 1'b0;
                    end
                end
            end
        end
    end

    // shared write data
    // wr_en picks which buffer takes it
    always_ff @(posedge clk_dfe) begin
        if (in_valid) begin
            wr_data <= in_data;
        end
    end

endmodule

// File: hw/prach_ctrl_pkg.sv
`include "prach_cfg.svh"

package prach_ctrl_pkg;

    // PRACH format code
    typedef logic [1:0] format_t;

    // 0 = 20 MHz, 1 = 10 MHz, 2 = 5 MHz, 3 = 15 MHz
    typedef logic [1:0] ch_bw_t;

    // block length and buffer fill, one bit wider than the index
    typedef logic [$clog2(`PRACH_FIFO_DEPTH):0] blk_len_t;

    // read sequencer states
    typedef enum logic [1:0] {
        seq_idle,
        seq_drain,
        seq_wait_last
    } seq_state_t;

    // samples per symbol block for a format code
    function automatic blk_len_t block_len(input format_t fmt);
        case (fmt)
            2'd0:    return blk_len_t'(`PRACH_LEN_F0);
            2'd1:    return blk_len_t'(`PRACH_LEN_F1);
            2'd2:    return blk_len_t'(`PRACH_LEN_F2);
            default: return blk_len_t'(`PRACH_LEN_F3);
        endcase
    endfunction

    // narrower carriers get more attenuation
    function automatic logic [1:0] gain_shift(input ch_bw_t bw);
        case (bw)
            2'd0:    return 2'd0;
            2'd1:    return 2'd1;
            2'd2:    return 2'd2;
            default: return 2'd1;
        endcase
    endfunction

endpackage

// File: hw/prach_sample_pkg.sv
`include "prach_cfg.svh"

package prach_sample_pkg;

    // one IQ sample
    // Q sits in the upper half, I in the lower half
    typedef logic [2*`PRACH_IQ_W-1:0] iq_t;

    // antenna number carried with each sample
    typedef logic [$clog2(`PRACH_N_ANT)-1:0] ant_id_t;

    // sample position inside a symbol block
    // sized by the buffer depth so the longest block fits
    typedef logic [$clog2(`PRACH_FIFO_DEPTH)-1:0] sample_idx_t;

endpackage

// File: hw/prach_cfg.svh
`ifndef PRACH_CFG_SVH
`define PRACH_CFG_SVH

// antennas multiplexed on the input stream
`define PRACH_N_ANT 4

// bits per I or Q part
`define PRACH_IQ_W 16

// words per antenna symbol buffer
// must hold the longest block
`define PRACH_FIFO_DEPTH 64

// cyclic prefix length field
`define PRACH_CP_W 10

// PRACH symbol block length per format code
`define PRACH_LEN_F0 64
`define PRACH_LEN_F1 32
`define PRACH_LEN_F2 16
`define PRACH_LEN_F3 48

`endif
